//--- Bender.yml
package:
  name: fw_ip1

sources:
  - design/fw_ip1_regs_pkg.sv
  - design/fw_ip1_test_pkg.sv
  - design/test_if.sv
  - design/config_regs.sv
  - design/configclk_generator.sv
  - design/exec_decoder.sv
  - design/test1_sequencer.sv
  - design/sw_readout.sv
  - design/fw_ip1_top.sv
  - target: test
    files:
      - testbench/tb_fw_ip1_assertions.sv
      - testbench/tb_fw_ip1.sv

//--- design/config_regs.sv
/* static configuration register and the array words
   written by opcode strobes from the software bus */
`timescale 1ns/1ns

module config_regs (
  input  logic        fw_axi_clk,
  input  logic        op_code_w_reset,
  input  logic        op_code_w_cfg_static,
  input  logic        op_code_w_cfg_array,
  input  logic [23:0] sw_write24,
  output logic [23:0] cfg_static,
  output fw_ip1_regs_pkg::cfg_word_t [fw_ip1_regs_pkg::CFG_WORDS-1:0] cfg_array
);
  import fw_ip1_regs_pkg::*;

  logic [CFG_ADDR_HI-CFG_ADDR_LO:0] wr_addr;  // target word of an array write
  cfg_word_t                        wr_word;

  assign wr_addr = sw_write24[CFG_ADDR_HI:CFG_ADDR_LO];
  assign wr_word = sw_write24[$bits(cfg_word_t)-1:0];  // low half of the bus

  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      cfg_static <= '0;
      cfg_array  <= '0;
    end else begin
      if (op_code_w_cfg_static) begin
        cfg_static <= sw_write24;  // whole 24-bit field
      end
      // compare against every slot so an address past the end hits nothing
      if (op_code_w_cfg_array) begin
        for (int i = 0; i < CFG_WORDS; i++) begin
          if (wr_addr == i) begin
            cfg_array[i] <= wr_word;
          end
        end
      end
    end
  end

endmodule

//--- design/configclk_generator.sv
/* counter based configuration clock
   period set in fw_axi_clk cycles, count exported as phase */
`timescale 1ns/1ns

module configclk_generator #(
  parameter int CNT_WIDTH = 7
) (
  input  logic                 fw_axi_clk,
  input  logic                 op_code_w_reset,
  input  logic [CNT_WIDTH-1:0] configclk_period,
  output logic [CNT_WIDTH-1:0] clk_counter,   // phase reference for the sequencer
  output logic                 configclk
);

  logic [CNT_WIDTH:0] half_period;  // one extra bit for period+1

  // runs 0 .. period then wraps
  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      clk_counter <= '0;
    end else if (clk_counter >= configclk_period) begin
      clk_counter <= '0;  // also catches a period lowered mid-count
    end else begin
      clk_counter <= clk_counter + 1'b1;
    end
  end

  // high for the first half of each wrap
  assign half_period = ({1'b0, configclk_period} + 1'b1) >> 1;
  assign configclk   = {1'b0, clk_counter} < half_period;

endmodule

//--- design/exec_decoder.sv
/* execute opcode decoder
   latches the test fields, checks them and issues the run start */
`timescale 1ns/1ns

module exec_decoder (
  input  logic        fw_axi_clk,
  input  logic        op_code_w_reset,
  input  logic        op_code_w_execute,
  input  logic [23:0] sw_write24,
  input  logic [fw_ip1_regs_pkg::PERIOD_WIDTH-1:0] configclk_period,
  test_if.decoder     tif
);
  import fw_ip1_test_pkg::*;

  logic [DELAY_HI-DELAY_LO:0]       req_delay;   // fields as seen on the bus
  logic [SAMPLE_HI-SAMPLE_LO:0]     req_sample;
  logic [TEST_NUM_HI-TEST_NUM_LO:0] req_number;
  logic                             fields_ok;
  logic                             accept;      // execute taken this edge

  assign req_delay  = sw_write24[DELAY_HI:DELAY_LO];
  assign req_sample = sw_write24[SAMPLE_HI:SAMPLE_LO];
  assign req_number = sw_write24[TEST_NUM_HI:TEST_NUM_LO];

  // both phase points must fall inside one config clock wrap
  assign fields_ok = (req_number == TEST1_NUMBER) &&
                     (req_delay >= MIN_DELAY) &&
                     (req_delay <= configclk_period) &&
                     (req_sample <= configclk_period);

  // a pending start counts as busy
  assign accept = op_code_w_execute && !tif.busy && !tif.start;

  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      tif.start <= 1'b0;
      tif.error <= 1'b0;
    end else begin
      tif.start <= accept && fields_ok;  // drops again on the next edge
      if (accept) begin
        tif.error <= !fields_ok;
      end
    end
  end

  // run fields held for the whole run, the bus is free for reads afterwards
  always_ff @(posedge fw_axi_clk) begin
    if (accept) begin
      tif.test_delay     <= req_delay;
      tif.test_sample    <= req_sample;
      tif.loopback       <= sw_write24[LOOPBACK_BIT];
      tif.mask_reset_not <= sw_write24[MASK_RESET_NOT_BIT];
    end
  end

endmodule

//--- design/fw_ip1_regs_pkg.sv
/* register map of the test controller
   static register fields, array sizes and sticky status bit positions */

package fw_ip1_regs_pkg;

  // --------------------
  // configuration array
  localparam int CFG_WORDS   = 4;   // 16-bit words in the serial chain image
  localparam int CFG_ADDR_HI = 23;  // word address inside sw_write24
  localparam int CFG_ADDR_LO = 16;

  typedef logic [15:0] cfg_word_t;  // one array word

  // --------------------
  // static register
  localparam int FAST_PERIOD_HI    = 6;  // config clock period in fw_axi_clk cycles
  localparam int FAST_PERIOD_LO    = 0;
  localparam int SUPER_PIX_SEL_BIT = 7;
  localparam int PERIOD_WIDTH      = FAST_PERIOD_HI - FAST_PERIOD_LO + 1;

  // --------------------
  // sticky status word
  localparam int STATUS_RESET      = 0;
  localparam int STATUS_W_STATIC   = 1;
  localparam int STATUS_R_STATIC   = 2;
  localparam int STATUS_W_ARRAY    = 3;
  localparam int STATUS_R_ARRAY    = 4;
  localparam int STATUS_R_DATA     = 5;
  localparam int STATUS_EXECUTE    = 6;
  localparam int STATUS_TEST1_DONE = 12;  // mirrors sequencer done
  localparam int STATUS_EXEC_ERROR = 31;  // mirrors decoder error

endpackage

//--- design/fw_ip1_test_pkg.sv
/* test run definitions
   execute field positions, sequencer states and chain sizes */

package fw_ip1_test_pkg;

  localparam int CHAIN_BITS = 64;              // length of the asic config chain
  localparam int DATA_WORDS = CHAIN_BITS / 32; // readout words of captured data

  // --------------------
  // execute word fields
  localparam int DELAY_HI           = 6;   // count at which the chain advances
  localparam int DELAY_LO           = 0;
  localparam int SAMPLE_HI          = 13;  // count at which config_out is sampled
  localparam int SAMPLE_LO          = 7;
  localparam int TEST_NUM_HI        = 17;
  localparam int TEST_NUM_LO        = 14;
  localparam int LOOPBACK_BIT       = 18;
  localparam int MASK_RESET_NOT_BIT = 23;  // skip the asic reset pulse

  localparam int TEST1_NUMBER = 1;  // only test kept in this block
  localparam int MIN_DELAY    = 3;  // smaller delays race the sample point

  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    RESET_NOT = 3'd1,
    LOAD      = 3'd2,
    SHIFT     = 3'd3,
    LATCH     = 3'd4,
    DONE      = 3'd5
  } test1_state_t;

  typedef logic [CHAIN_BITS-1:0] chain_t;

  // level on fw_config_load
  typedef enum logic {
    SHIFT_REG   = 1'b0,
    LOAD_CONFIG = 1'b1
  } shift_reg_mode_t;

endpackage

//--- design/fw_ip1_top.sv
/* test controller top level
   config registers, config clock, execute decoder, test1 and readout */
`timescale 1ns/1ns

module fw_ip1_top (
  input  logic        fw_axi_clk,
  input  logic        op_code_w_reset,
  input  logic        op_code_w_cfg_static,
  input  logic        op_code_r_cfg_static,
  input  logic        op_code_w_cfg_array,
  input  logic        op_code_r_cfg_array,
  input  logic        op_code_r_data_array,
  input  logic        op_code_w_status_clear,
  input  logic        op_code_w_execute,
  input  logic [23:0] sw_write24,
  input  logic        fw_config_out,       // serial chain return from the asic
  output logic [31:0] fw_read_data32,
  output logic [31:0] fw_read_status32,
  output logic        fw_super_pixel_sel,
  output logic        fw_config_clk,
  output logic        fw_reset_not,
  output logic        fw_config_in,
  output logic        fw_config_load
);
  import fw_ip1_regs_pkg::*;

  logic [23:0]                   cfg_static;
  cfg_word_t [CFG_WORDS-1:0]     cfg_array;
  logic [PERIOD_WIDTH-1:0]       configclk_period;
  logic [PERIOD_WIDTH-1:0]       clk_counter;
  logic                          configclk;

  test_if tif ();  // run control between decoder, sequencer and readout

  assign configclk_period   = cfg_static[FAST_PERIOD_HI:FAST_PERIOD_LO];
  assign fw_super_pixel_sel = cfg_static[SUPER_PIX_SEL_BIT];

  config_regs u_config_regs (
    .fw_axi_clk, .op_code_w_reset, .op_code_w_cfg_static, .op_code_w_cfg_array,
    .sw_write24, .cfg_static, .cfg_array
  );

  configclk_generator #(.CNT_WIDTH(PERIOD_WIDTH)) u_configclk_generator (
    .fw_axi_clk, .op_code_w_reset, .configclk_period, .clk_counter, .configclk
  );

  exec_decoder u_exec_decoder (
    .fw_axi_clk, .op_code_w_reset, .op_code_w_execute, .sw_write24,
    .configclk_period, .tif(tif.decoder)
  );

  test1_sequencer u_test1_sequencer (
    .fw_axi_clk, .op_code_w_reset, .clk_counter, .configclk, .cfg_array,
    .fw_config_out, .tif(tif.sequencer), .fw_config_clk, .fw_reset_not,
    .fw_config_in, .fw_config_load
  );

  sw_readout u_sw_readout (
    .fw_axi_clk, .op_code_w_reset, .op_code_w_cfg_static, .op_code_r_cfg_static,
    .op_code_w_cfg_array, .op_code_r_cfg_array, .op_code_r_data_array,
    .op_code_w_status_clear, .op_code_w_execute, .sw_write24, .cfg_static,
    .cfg_array, .tif(tif.readout), .fw_read_data32, .fw_read_status32
  );

endmodule

//--- design/sw_readout.sv
/* software read mux with address range checks
   and the sticky status word with its clear */
`timescale 1ns/1ns

module sw_readout (
  input  logic        fw_axi_clk,
  input  logic        op_code_w_reset,
  input  logic        op_code_w_cfg_static,
  input  logic        op_code_r_cfg_static,
  input  logic        op_code_w_cfg_array,
  input  logic        op_code_r_cfg_array,
  input  logic        op_code_r_data_array,
  input  logic        op_code_w_status_clear,
  input  logic        op_code_w_execute,
  input  logic [23:0] sw_write24,
  input  logic [23:0] cfg_static,
  input  fw_ip1_regs_pkg::cfg_word_t [fw_ip1_regs_pkg::CFG_WORDS-1:0] cfg_array,
  test_if.readout     tif,
  output logic [31:0] fw_read_data32,
  output logic [31:0] fw_read_status32
);
  import fw_ip1_regs_pkg::*;
  import fw_ip1_test_pkg::*;

  logic [CFG_ADDR_HI-CFG_ADDR_LO:0] rd_addr;
  logic [31:0]                      status_q;
  logic                             reset_q;  // reset strobe one cycle late

  assign rd_addr = sw_write24[CFG_ADDR_HI:CFG_ADDR_LO];

  // --------------------
  // read mux, zero unless a read strobe is up
  always_comb begin
    fw_read_data32 = '0;
    if (op_code_r_cfg_static) begin
      fw_read_data32 = {8'h00, cfg_static};
    end else if (op_code_r_cfg_array) begin
      for (int i = 0; i < CFG_WORDS; i++) begin  // word past the end stays zero
        if (rd_addr == i)     fw_read_data32[15:0]  = cfg_array[i];
        if (rd_addr + 1 == i) fw_read_data32[31:16] = cfg_array[i];
      end
    end else if (op_code_r_data_array) begin
      for (int i = 0; i < DATA_WORDS; i++) begin
        if (rd_addr == i) fw_read_data32 = tif.capture[i*32 +: 32];
      end
    end
  end

  // --------------------
  // sticky status
  always_ff @(posedge fw_axi_clk) begin
    reset_q <= op_code_w_reset;
    if (op_code_w_reset || op_code_w_status_clear) begin
      status_q <= '0;  // clear beats any set
    end else begin
      if (reset_q)              status_q[STATUS_RESET]    <= 1'b1;  // lands once reset drops
      if (op_code_w_cfg_static) status_q[STATUS_W_STATIC] <= 1'b1;
      if (op_code_r_cfg_static) status_q[STATUS_R_STATIC] <= 1'b1;
      if (op_code_w_cfg_array)  status_q[STATUS_W_ARRAY]  <= 1'b1;
      if (op_code_r_cfg_array)  status_q[STATUS_R_ARRAY]  <= 1'b1;
      if (op_code_r_data_array) status_q[STATUS_R_DATA]   <= 1'b1;
      if (op_code_w_execute)    status_q[STATUS_EXECUTE]  <= 1'b1;
      status_q[STATUS_TEST1_DONE] <= tif.done;   // level copies
      status_q[STATUS_EXEC_ERROR] <= tif.error;
    end
  end

  assign fw_read_status32 = status_q;

endmodule

//--- design/test1_sequencer.sv
/* test1 state machine with the outgoing chain shift register
   and the capture register for the returned bits */
`timescale 1ns/1ns

module test1_sequencer (
  input  logic fw_axi_clk,
  input  logic op_code_w_reset,
  input  logic [fw_ip1_regs_pkg::PERIOD_WIDTH-1:0] clk_counter,
  input  logic configclk,
  input  fw_ip1_regs_pkg::cfg_word_t [fw_ip1_regs_pkg::CFG_WORDS-1:0] cfg_array,
  input  logic fw_config_out,
  test_if.sequencer tif,
  output logic fw_config_clk,
  output logic fw_reset_not,
  output logic fw_config_in,
  output logic fw_config_load
);
  import fw_ip1_test_pkg::*;

  test1_state_t                  state;
  chain_t                        chain_sr;     // bit 0 drives config_in
  logic [$clog2(CHAIN_BITS)-1:0] bit_cnt;      // captures so far
  logic                          sampled;      // current bit already captured
  logic                          wrap_seen;    // first counter zero passed
  logic                          at_wrap;
  logic                          wrap_done;    // one full wrap elapsed
  logic                          sample_now;
  logic                          shift_now;
  logic                          capture_bit;

  assign at_wrap   = (clk_counter == '0);
  assign wrap_done = at_wrap && wrap_seen;

  // sample strictly before shift for every bit
  assign sample_now  = (state == SHIFT) && !sampled && (clk_counter == tif.test_sample);
  assign shift_now   = (state == SHIFT) && sampled && (clk_counter == tif.test_delay);
  assign capture_bit = tif.loopback ? fw_config_in : fw_config_out;

  // --------------------
  // control
  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      state        <= IDLE;
      tif.busy     <= 1'b0;
      tif.done     <= 1'b0;
      fw_reset_not <= 1'b0;  // asic held in reset with us
      wrap_seen    <= 1'b0;
      sampled      <= 1'b0;
      bit_cnt      <= '0;
    end else begin
      case (state)
        IDLE, DONE: begin
          fw_reset_not <= 1'b1;
          if (tif.start) begin
            state        <= RESET_NOT;
            tif.busy     <= 1'b1;
            tif.done     <= 1'b0;
            wrap_seen    <= 1'b0;
            fw_reset_not <= tif.mask_reset_not;  // masked run keeps asic out of reset
          end
        end
        RESET_NOT: begin
          if (at_wrap) wrap_seen <= 1'b1;
          if (wrap_done) begin
            state        <= LOAD;
            fw_reset_not <= 1'b1;
          end
        end
        LOAD: begin
          state   <= SHIFT;
          bit_cnt <= '0;
          sampled <= 1'b0;
        end
        SHIFT: begin
          if (sample_now) begin
            sampled <= 1'b1;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == CHAIN_BITS - 1) begin  // last bit in
              state     <= LATCH;
              wrap_seen <= 1'b0;
            end
          end
          if (shift_now) sampled <= 1'b0;
        end
        LATCH: begin
          if (at_wrap) wrap_seen <= 1'b1;
          if (wrap_done) begin
            state    <= DONE;
            tif.busy <= 1'b0;
            tif.done <= 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // --------------------
  // chain out and capture in
  always_ff @(posedge fw_axi_clk) begin
    if (state == LOAD) begin
      chain_sr <= cfg_array;  // word 0 goes out first, lsb first
    end else if (shift_now) begin
      chain_sr <= {1'b0, chain_sr[CHAIN_BITS-1:1]};
    end
    if (sample_now) begin
      tif.capture <= {capture_bit, tif.capture[CHAIN_BITS-1:1]};  // lands at bit 0 after 64
    end
  end

  // asic pins, quiet outside their states
  assign fw_config_clk  = (state == SHIFT) && configclk;
  assign fw_config_in   = (state == SHIFT) && chain_sr[0];
  assign fw_config_load = (state == LATCH) ? LOAD_CONFIG : SHIFT_REG;

endmodule

//--- design/test_if.sv
/* control and result of one test run
   shared by the execute decoder, the sequencer and the readout */
`timescale 1ns/1ns

interface test_if;
  import fw_ip1_test_pkg::*;

  // decoder side
  logic                       start;          // one-cycle run request
  logic [DELAY_HI-DELAY_LO:0] test_delay;
  logic [SAMPLE_HI-SAMPLE_LO:0] test_sample;
  logic                       loopback;
  logic                       mask_reset_not;
  logic                       error;          // level, last execute was rejected

  // sequencer side
  logic   busy;
  logic   done;     // level, held until the next start
  chain_t capture;  // bits read back from the chain

  modport decoder (
    output start, test_delay, test_sample, loopback, mask_reset_not, error,
    input  busy
  );

  modport sequencer (
    input  start, test_delay, test_sample, loopback, mask_reset_not,
    output busy, done, capture
  );

  modport readout (
    input done, error, capture
  );

endinterface

//--- fw_ip1.f
design/fw_ip1_regs_pkg.sv
design/fw_ip1_test_pkg.sv
design/test_if.sv
design/config_regs.sv
design/configclk_generator.sv
design/exec_decoder.sv
design/test1_sequencer.sv
design/sw_readout.sv
design/fw_ip1_top.sv
testbench/tb_fw_ip1_assertions.sv
testbench/tb_fw_ip1.sv

//--- testbench/tb_fw_ip1.sv
/* testbench for the test controller top level
   model of registers and status, compare process, watchdog, six tests */
`timescale 1ns/1ns

module tb_fw_ip1;
  import fw_ip1_regs_pkg::*;
  import fw_ip1_test_pkg::*;

  localparam int CLK_PERIOD  = 100;
  localparam int RUN_PERIOD  = 7;                                 // config clock period of runs
  localparam int RUN_CYCLES  = (CHAIN_BITS + 4) * (RUN_PERIOD + 1);
  localparam int WATCHDOG_NS = (3 * RUN_CYCLES + 1000) * CLK_PERIOD;

  // ids match the status bit of each opcode
  typedef enum int {
    OP_RESET = 0, OP_W_STATIC = 1, OP_R_STATIC = 2, OP_W_ARRAY = 3,
    OP_R_ARRAY = 4, OP_R_DATA = 5, OP_EXECUTE = 6, OP_CLEAR = 7
  } op_t;
  typedef enum int {REF_STATIC, REF_ARRAY, REF_DATA, REF_STATUS, REF_CHAIN} ref_kind_t;

  logic        fw_axi_clk;
  logic        op_code_w_reset;
  logic        op_code_w_cfg_static;
  logic        op_code_r_cfg_static;
  logic        op_code_w_cfg_array;
  logic        op_code_r_cfg_array;
  logic        op_code_r_data_array;
  logic        op_code_w_status_clear;
  logic        op_code_w_execute;
  logic [23:0] sw_write24;
  logic        fw_config_out;
  logic [31:0] fw_read_data32;
  logic [31:0] fw_read_status32;
  logic        fw_super_pixel_sel;
  logic        fw_config_clk;
  logic        fw_reset_not;
  logic        fw_config_in;
  logic        fw_config_load;

  // --------------------
  // model state
  logic [23:0] m_static;
  cfg_word_t   m_array [CFG_WORDS];
  logic [6:0]  m_sticky;                // opcode bits of the status word
  logic        m_done;
  logic        m_error;
  chain_t      m_capture;
  logic [31:0] last_read;
  integer      seed;
  int          errors;
  int          err_mark;                // errors before the current test
  int          checks_posted;
  int          checks_done;
  int          reset_lows;              // falling edges of fw_reset_not
  int          clk_rises;               // rising edges of fw_config_clk in a run
  int          load_pulses;             // rising edges of fw_config_load in a run
  logic        prev_reset_not;
  logic        prev_config_clk;
  logic        prev_config_load;
  chain_t      asic_chain;              // chain as the asic clocks it in
  string       name_q[$];
  logic [63:0] got_q[$];
  logic [63:0] exp_q[$];

  fw_ip1_top UUT (.*);

  initial fw_axi_clk = 1'b0;
  always #(CLK_PERIOD / 2) fw_axi_clk = ~fw_axi_clk;

  // expected chain, reads and status from the model
  function automatic logic [63:0] ref_model(input ref_kind_t kind, input int addr);
    chain_t      chain;
    logic [63:0] res;
    res = '0;
    for (int i = 0; i < CFG_WORDS; i++) begin
      chain[i*16 +: 16] = m_array[i];  // word 0 leaves first, lsb first
    end
    case (kind)
      REF_STATIC: res = {40'h0, m_static};
      REF_ARRAY: begin
        if (addr < CFG_WORDS)     res[15:0]  = m_array[addr];
        if (addr + 1 < CFG_WORDS) res[31:16] = m_array[addr + 1];  // past the end is zero
      end
      REF_DATA: if (addr < DATA_WORDS) res[31:0] = m_capture[addr*32 +: 32];
      REF_STATUS: begin
        res[6:0]               = m_sticky;
        res[STATUS_TEST1_DONE] = m_done;
        res[STATUS_EXEC_ERROR] = m_error;
      end
      REF_CHAIN: res = chain;
      default: res = '0;
    endcase
    return res;
  endfunction

  // execute rule: test 1 only, both phase points inside one wrap
  function automatic logic exec_valid(input logic [23:0] w);
    logic [6:0] period;
    period = m_static[FAST_PERIOD_HI:FAST_PERIOD_LO];
    return (w[TEST_NUM_HI:TEST_NUM_LO] == TEST1_NUMBER) && (w[DELAY_HI:DELAY_LO] >= MIN_DELAY)
        && (w[DELAY_HI:DELAY_LO] <= period) && (w[SAMPLE_HI:SAMPLE_LO] <= period);
  endfunction

  function automatic logic [23:0] exec_word(input int num, input int delay, input int sample,
                                            input logic loopback, input logic mask);
    logic [23:0] w;
    w = '0;
    w[DELAY_HI:DELAY_LO]       = delay;
    w[SAMPLE_HI:SAMPLE_LO]     = sample;
    w[TEST_NUM_HI:TEST_NUM_LO] = num;
    w[LOOPBACK_BIT]            = loopback;
    w[MASK_RESET_NOT_BIT]      = mask;
    return w;
  endfunction

  task automatic post_check(input string name, input logic [63:0] got, input logic [63:0] exp);
    name_q.push_back(name);
    got_q.push_back(got);
    exp_q.push_back(exp);
    checks_posted++;
  endtask

  // --------------------
  // compare process
  always begin : compare
    string       name;
    logic [63:0] got;
    logic [63:0] exp;
    wait (got_q.size() > 0);
    name = name_q.pop_front();
    got  = got_q.pop_front();
    exp  = exp_q.pop_front();
    assert (got === exp) else begin
      $display("ERR %s: got %h expected %h", name, got, exp);
      errors++;
    end
    checks_done++;
  end

  // asic side of the pins, sampled mid-cycle
  always @(negedge fw_axi_clk) begin
    if (prev_reset_not && !fw_reset_not) reset_lows++;
    if (!prev_config_clk && fw_config_clk) begin
      clk_rises++;
      asic_chain = {fw_config_in, asic_chain[CHAIN_BITS-1:1]};  // asic shifts on the rise
    end
    if (!prev_config_load && fw_config_load) load_pulses++;
    prev_reset_not   = fw_reset_not;
    prev_config_clk  = fw_config_clk;
    prev_config_load = fw_config_load;
  end

  // one opcode for one cycle, model follows after the edge
  task automatic strobe(input op_t op, input logic [23:0] data);
    @(posedge fw_axi_clk);
    #10;
    sw_write24 = data;
    case (op)
      OP_RESET:    op_code_w_reset        = 1'b1;
      OP_W_STATIC: op_code_w_cfg_static   = 1'b1;
      OP_R_STATIC: op_code_r_cfg_static   = 1'b1;
      OP_W_ARRAY:  op_code_w_cfg_array    = 1'b1;
      OP_R_ARRAY:  op_code_r_cfg_array    = 1'b1;
      OP_R_DATA:   op_code_r_data_array   = 1'b1;
      OP_EXECUTE:  op_code_w_execute      = 1'b1;
      default:     op_code_w_status_clear = 1'b1;
    endcase
    @(negedge fw_axi_clk);
    last_read = fw_read_data32;  // read mux is combinational
    @(posedge fw_axi_clk);
    #10;
    {op_code_w_reset, op_code_w_cfg_static, op_code_r_cfg_static, op_code_w_cfg_array,
     op_code_r_cfg_array, op_code_r_data_array, op_code_w_execute, op_code_w_status_clear} = '0;
    case (op)
      OP_W_STATIC: m_static = data;
      OP_W_ARRAY: if (data[CFG_ADDR_HI:CFG_ADDR_LO] < CFG_WORDS) m_array[data[23:16]] = data[15:0];
      OP_EXECUTE: m_error = !exec_valid(data);
      OP_CLEAR:   m_sticky = '0;
      OP_RESET: begin
        m_static = '0;
        m_sticky = '0;
        m_done   = 1'b0;
        m_error  = 1'b0;
        foreach (m_array[i]) m_array[i] = '0;
      end
      default: ;
    endcase
    if (op != OP_CLEAR) m_sticky[op] = 1'b1;
  endtask

  task automatic check_read(input op_t op, input int addr, input ref_kind_t kind);
    strobe(op, 24'(addr) << CFG_ADDR_LO);
    post_check("fw_read_data32", last_read, ref_model(kind, addr));
  endtask

  // level bits trail the flags by a cycle
  task automatic check_status();
    repeat (2) @(posedge fw_axi_clk);
    @(negedge fw_axi_clk);
    post_check("fw_read_status32", fw_read_status32, ref_model(REF_STATUS, 0));
  endtask

  task automatic run_test1(input logic [23:0] word);
    int   waited;
    logic valid;
    valid       = exec_valid(word);
    reset_lows  = 0;
    clk_rises   = 0;
    load_pulses = 0;
    strobe(OP_EXECUTE, word);
    if (valid) begin
      repeat (4) @(posedge fw_axi_clk);  // old done level drops first
      waited = 0;
      @(negedge fw_axi_clk);
      while (!fw_read_status32[STATUS_TEST1_DONE] && waited < RUN_CYCLES + 20) begin
        @(negedge fw_axi_clk);
        waited++;
      end
      assert (fw_read_status32[STATUS_TEST1_DONE]) else begin
        $display("test1 run did not reach done within %0d cycles", RUN_CYCLES + 20);
        errors++;
      end
      m_done    = 1'b1;
      m_capture = word[LOOPBACK_BIT] ? ref_model(REF_CHAIN, 0) : {CHAIN_BITS{fw_config_out}};
    end
  endtask

  task automatic end_test(input string title);
    wait (checks_done == checks_posted);
    $display("test %s: %0d errors", title, errors - err_mark);
    err_mark = errors;
  endtask

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
    $display("TESTBENCH FAILED");
    $finish;
  end

  // --------------------
  // stimulus
  initial begin : stimulus
    logic [23:0] value;
    logic [23:0] data;
    op_t         op;
    seed           = 32'hc078df4f;
    {op_code_w_cfg_static, op_code_r_cfg_static, op_code_w_cfg_array, op_code_r_cfg_array,
     op_code_r_data_array, op_code_w_execute, op_code_w_status_clear} = '0;
    op_code_w_reset  = 1'b1;
    sw_write24       = '0;
    fw_config_out    = 1'b0;
    prev_reset_not   = 1'b0;
    prev_config_clk  = 1'b0;
    prev_config_load = 1'b0;
    {errors, err_mark, checks_posted, checks_done, reset_lows, clk_rises, load_pulses} = '0;
    {m_static, m_done, m_error, m_capture, asic_chain} = '0;
    foreach (m_array[i]) m_array[i] = '0;
    repeat (5) @(posedge fw_axi_clk);
    #10;
    op_code_w_reset = 1'b0;
    m_sticky        = 7'b1;  // reset strobe leaves bit 0 behind

    value = $random(seed);
    for (int k = 0; k < 2; k++) begin  // both polarities of super pixel select
      strobe(OP_W_STATIC, value);
      @(negedge fw_axi_clk);
      post_check("fw_super_pixel_sel", fw_super_pixel_sel, value[SUPER_PIX_SEL_BIT]);
      check_read(OP_R_STATIC, 0, REF_STATIC);
      value = ~value;
    end
    end_test("1 static write and read");

    for (int a = 0; a < CFG_WORDS; a++) strobe(OP_W_ARRAY, {8'(a), 16'($random(seed))});
    strobe(OP_W_ARRAY, {8'(CFG_WORDS), 16'hdead});  // past the end, dropped
    for (int a = 0; a <= CFG_WORDS; a++) check_read(OP_R_ARRAY, a, REF_ARRAY);
    end_test("2 array write and pair readback");

    check_status();
    strobe(OP_CLEAR, '0);
    check_status();  // all zero here
    for (int k = OP_W_STATIC; k <= OP_EXECUTE; k++) begin
      op = op_t'(k);
      case (op)
        OP_W_STATIC: data = m_static;
        OP_W_ARRAY:  data = 24'hff0000;               // out of range address
        OP_EXECUTE:  data = exec_word(0, 5, 2, 1'b0, 1'b0);  // rejected test number
        default:     data = '0;
      endcase
      strobe(op, data);
      check_status();
    end
    strobe(OP_CLEAR, '0);
    check_status();
    end_test("3 status bits and clear");

    strobe(OP_W_STATIC, RUN_PERIOD);
    for (int a = 0; a < CFG_WORDS; a++) strobe(OP_W_ARRAY, {8'(a), 16'($random(seed))});
    run_test1(exec_word(TEST1_NUMBER, 5, 2, 1'b1, 1'b0));
    check_status();
    post_check("fw_reset_not low pulses", reset_lows, 1);
    post_check("fw_config_clk rising edges", clk_rises, CHAIN_BITS);  // one clock per bit
    post_check("fw_config_load pulses", load_pulses, 1);
    post_check("fw_config_in", asic_chain, ref_model(REF_CHAIN, 0));
    for (int a = 0; a <= DATA_WORDS; a++) check_read(OP_R_DATA, a, REF_DATA);
    end_test("4 loopback run");

    @(posedge fw_axi_clk);
    #10;
    fw_config_out = 1'b1;  // asic returns ones
    run_test1(exec_word(TEST1_NUMBER, 3, 6, 1'b0, 1'b1));
    check_status();
    post_check("fw_reset_not low pulses", reset_lows, 0);
    post_check("fw_config_clk rising edges", clk_rises, CHAIN_BITS);
    post_check("fw_config_load pulses", load_pulses, 1);
    for (int a = 0; a < DATA_WORDS; a++) check_read(OP_R_DATA, a, REF_DATA);
    fw_config_out = 1'b0;
    end_test("5 capture run with masked reset");

    strobe(OP_RESET, '0);  // drops done, capture register keeps its bits
    strobe(OP_W_STATIC, RUN_PERIOD);
    run_test1(exec_word(TEST1_NUMBER, MIN_DELAY - 1, 2, 1'b1, 1'b0));
    check_status();
    post_check("fw_reset_not low pulses", reset_lows, 0);  // no run was started
    for (int a = 0; a < DATA_WORDS; a++) check_read(OP_R_DATA, a, REF_DATA);
    run_test1(exec_word(2, 5, 2, 1'b1, 1'b0));
    check_status();
    post_check("fw_reset_not low pulses", reset_lows, 0);
    for (int a = 0; a < DATA_WORDS; a++) check_read(OP_R_DATA, a, REF_DATA);
    end_test("6 rejected execute");

    $display("checks: %0d, errors: %0d", checks_done, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- testbench/tb_fw_ip1_assertions.sv
/* concurrent checks on the test1 sequencer pins and run flags
   bound into every test1_sequencer instance */
`timescale 1ns/1ns

module tb_fw_ip1_assertions (
  input logic                          fw_axi_clk,
  input logic                          op_code_w_reset,
  input fw_ip1_test_pkg::test1_state_t state,
  input logic                          busy,
  input logic                          done,
  input logic                          fw_config_clk,
  input logic                          fw_reset_not
);
  import fw_ip1_test_pkg::*;

  // config clock reaches the asic only while shifting
  clk_only_in_shift: assert property (@(posedge fw_axi_clk) disable iff (op_code_w_reset)
    (state != SHIFT) |-> !fw_config_clk)
    else $error("fw_config_clk high outside SHIFT");

  no_done_while_busy: assert property (@(posedge fw_axi_clk) disable iff (op_code_w_reset)
    !(done && busy))
    else $error("done and busy high together");

  // first cycle after reset still shows the reset level
  reset_pulse_in_state: assert property (@(posedge fw_axi_clk) disable iff (op_code_w_reset)
    !fw_reset_not |-> (state == RESET_NOT) || $past(op_code_w_reset))
    else $error("fw_reset_not low outside RESET_NOT");

endmodule

bind test1_sequencer tb_fw_ip1_assertions u_sequencer_assertions (
  .fw_axi_clk, .op_code_w_reset, .state, .busy(tif.busy), .done(tif.done),
  .fw_config_clk, .fw_reset_not
);
